/* rtl/fb_bus_macros.svh */
// Front-end bus width macros
`ifndef FB_BUS_MACROS_SVH
`define FB_BUS_MACROS_SVH

// Byte address width
`define FB_AW 32

// Request write data width
`define FB_DW 32

// Response data width, same as FB_DW in this core
`define FB_IW 32

// Memory depth in words
// Word indices at or above this are out of range
`define FB_MEM_WORDS 256

`endif

/* rtl/fb_bus_pkg.sv */
// Front-end bus types
`default_nettype none

`include "fb_bus_macros.svh"

package fb_bus_pkg;

   // Exception code carried with requests and responses
   // Bus error comes only from the memory slave
   typedef enum logic [1:0] {
      EXC_NONE = 2'b00,
      EXC_PAGE = 2'b01,
      EXC_PRIV = 2'b10,
      EXC_BUS  = 2'b11
   } fb_exc_e;

   // A channel payload
   // All-zero mask means read
   typedef struct packed {
      logic [`FB_AW-1:0]   addr;
      logic [`FB_DW-1:0]   data;
      logic [`FB_DW/8-1:0] wmsk;
      fb_exc_e             exc;
   } fb_req_t;

   // B channel payload
   typedef struct packed {
      logic [`FB_IW-1:0] data;
      fb_exc_e           exc;
   } fb_rsp_t;

endpackage

`default_nettype wire

/* rtl/fb_bus_if.sv */
// Front-end bus channel pair
`timescale 1ns/1ps
`default_nettype none

interface fb_bus_if
   import fb_bus_pkg::*;
();

   // A channel, request from master
   logic    a_valid;
   logic    a_ready;
   fb_req_t a_req;

   // B channel, response from slave
   logic    b_valid;
   logic    b_ready;
   fb_rsp_t b_rsp;

   // Transfer on any edge with valid and ready both high
   // Valid and payload held stable until then

   // Requesting side
   modport master (
      output a_valid,
      output a_req,
      input  a_ready,
      input  b_valid,
      input  b_rsp,
      output b_ready
   );

   // Responding side
   modport slave (
      input  a_valid,
      input  a_req,
      output a_ready,
      output b_valid,
      output b_rsp,
      input  b_ready
   );

endinterface

`default_nettype wire

/* rtl/fb_arbiter.sv */
// Front-end bus arbiter
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter
   import fb_bus_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   fb_bus_if.slave    ibus,
   fb_bus_if.slave    dbus,
   fb_bus_if.master   mbus
);

   // Grant state encoding
   typedef enum logic [1:0] {
      GNT_IDLE = 2'b00,
      GNT_IBUS = 2'b01,
      GNT_DBUS = 2'b11
   } gnt_e;

   gnt_e    gnt_q;
   gnt_e    gnt_d;
   logic    sel_ibus;
   logic    sel_dbus;
   logic    ibus_b_hds;
   logic    dbus_b_hds;
   fb_req_t ibus_req;

   // Next owner with dbus first
   function automatic gnt_e pick_grant(input logic d_valid, input logic i_valid);
      gnt_e g;
      if (d_valid)
         g = GNT_DBUS;
      else if (i_valid)
         g = GNT_IBUS;
      else
         g = GNT_IDLE;
      return g;
   endfunction

   // Response taken by owner
   assign ibus_b_hds = ibus.b_valid & ibus.b_ready;
   assign dbus_b_hds = dbus.b_valid & dbus.b_ready;

   always_comb
   begin
      gnt_d = gnt_q;
      case (gnt_q)
         GNT_IDLE:
            gnt_d = pick_grant(dbus.a_valid, ibus.a_valid);
         // Re-arbitrate on the closing handshake without an idle gap
         GNT_IBUS:
            if (ibus_b_hds)
               gnt_d = pick_grant(dbus.a_valid, ibus.a_valid);
         GNT_DBUS:
            if (dbus_b_hds)
               gnt_d = pick_grant(dbus.a_valid, ibus.a_valid);
         default:
            gnt_d = GNT_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         gnt_q <= GNT_IDLE;
      else
         gnt_q <= gnt_d;
   end

   assign sel_ibus = (gnt_q == GNT_IBUS);
   assign sel_dbus = (gnt_q == GNT_DBUS);

   // Fetch side is read-only so data and mask are stripped
   always_comb
   begin
      ibus_req      = ibus.a_req;
      ibus_req.data = '0;
      ibus_req.wmsk = '0;
   end

   // A channel steering
   assign mbus.a_valid = (sel_dbus & dbus.a_valid) | (sel_ibus & ibus.a_valid);
   assign mbus.a_req   = sel_dbus ? dbus.a_req : ibus_req;
   assign dbus.a_ready = sel_dbus & mbus.a_ready;
   assign ibus.a_ready = sel_ibus & mbus.a_ready;

   // B channel returns to the owner only
   assign mbus.b_ready = (sel_dbus & dbus.b_ready) | (sel_ibus & ibus.b_ready);
   assign dbus.b_valid = sel_dbus & mbus.b_valid;
   assign ibus.b_valid = sel_ibus & mbus.b_valid;
   assign dbus.b_rsp   = sel_dbus ? mbus.b_rsp : '0;
   assign ibus.b_rsp   = sel_ibus ? mbus.b_rsp : '0;

endmodule

`default_nettype wire

/* rtl/fb_mem_slave.sv */
// Front-end bus memory slave
`timescale 1ns/1ps
`default_nettype none

`include "fb_bus_macros.svh"

module fb_mem_slave
   import fb_bus_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   fb_bus_if.slave  bus
);

   localparam int IDX_W = $clog2(`FB_MEM_WORDS);

   // Word storage
   logic [`FB_DW-1:0] mem [`FB_MEM_WORDS];

   fb_req_t           req;
   fb_rsp_t           rsp_d;
   fb_rsp_t           rsp_q;
   logic              rsp_valid_q;
   logic              a_hds;
   logic              b_hds;
   logic [`FB_AW-3:0] word_full;
   logic [IDX_W-1:0]  word_idx;
   logic              out_of_range;
   logic              req_exc;
   logic              wr_en;

   assign req = bus.a_req;

   // Word index from byte address
   assign word_full    = req.addr[`FB_AW-1:2];
   assign word_idx     = word_full[IDX_W-1:0];
   assign out_of_range = (word_full >= `FB_MEM_WORDS);
   assign req_exc      = (req.exc != EXC_NONE);

   // Single slot, accept only while empty
   assign bus.a_ready = ~rsp_valid_q;
   assign a_hds       = bus.a_valid & bus.a_ready;
   assign b_hds       = bus.b_valid & bus.b_ready;

   // Write only for clean, in-range requests with a mask bit set
   assign wr_en = a_hds & ~req_exc & ~out_of_range & (|req.wmsk);

   // Response selection
   always_comb
   begin
      if (req_exc)
      begin
         // Upstream fault, no memory access
         rsp_d.data = '0;
         rsp_d.exc  = req.exc;
      end
      else if (out_of_range)
      begin
         rsp_d.data = '0;
         rsp_d.exc  = EXC_BUS;
      end
      else
      begin
         // Old word, before any write on this edge
         rsp_d.data = mem[word_idx];
         rsp_d.exc  = EXC_NONE;
      end
   end

   // Memory, cleared on reset
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int w = 0; w < `FB_MEM_WORDS; w++)
            mem[w] <= '0;
      end
      else if (wr_en)
      begin
         // Byte lanes under the mask
         for (int b = 0; b < `FB_DW/8; b++)
            if (req.wmsk[b])
               mem[word_idx][8*b +: 8] <= req.data[8*b +: 8];
      end
   end

   // Response valid flag
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rsp_valid_q <= 1'b0;
      else if (a_hds)
         rsp_valid_q <= 1'b1;
      else if (b_hds)
         rsp_valid_q <= 1'b0;
   end

   // Response payload, loaded on accept
   always_ff @(posedge clk)
   begin
      if (a_hds)
         rsp_q <= rsp_d;
   end

   // Held until master takes it
   assign bus.b_valid = rsp_valid_q;
   assign bus.b_rsp   = rsp_q;

endmodule

`default_nettype wire

/* rtl/fb_subsys_top.sv */
// Front-end bus subsystem top
`timescale 1ns/1ps
`default_nettype none

`include "fb_bus_macros.svh"

module fb_subsys_top
   import fb_bus_pkg::*;
(
   input  logic                clk,
   input  logic                rst_n,
   // Instruction fetch bus
   input  logic                ibus_a_valid,
   output logic                ibus_a_ready,
   input  logic [`FB_AW-1:0]   ibus_a_addr,
   input  logic [1:0]          ibus_a_exc,
   output logic                ibus_b_valid,
   input  logic                ibus_b_ready,
   output logic [`FB_IW-1:0]   ibus_b_data,
   output logic [1:0]          ibus_b_exc,
   // Data bus
   input  logic                dbus_a_valid,
   output logic                dbus_a_ready,
   input  logic [`FB_AW-1:0]   dbus_a_addr,
   input  logic [`FB_DW-1:0]   dbus_a_data,
   input  logic [`FB_DW/8-1:0] dbus_a_wmsk,
   input  logic [1:0]          dbus_a_exc,
   output logic                dbus_b_valid,
   input  logic                dbus_b_ready,
   output logic [`FB_IW-1:0]   dbus_b_data,
   output logic [1:0]          dbus_b_exc
);

   fb_bus_if ibus_if ();
   fb_bus_if dbus_if ();
   fb_bus_if mbus_if ();

   // Fetch side, no write data or mask
   assign ibus_if.a_valid = ibus_a_valid;
   assign ibus_if.a_req   = '{addr: ibus_a_addr, data: '0, wmsk: '0,
                              exc: fb_exc_e'(ibus_a_exc)};
   assign ibus_if.b_ready = ibus_b_ready;
   assign ibus_a_ready    = ibus_if.a_ready;
   assign ibus_b_valid    = ibus_if.b_valid;
   assign ibus_b_data     = ibus_if.b_rsp.data;
   assign ibus_b_exc      = ibus_if.b_rsp.exc;

   // Data side
   assign dbus_if.a_valid = dbus_a_valid;
   assign dbus_if.a_req   = '{addr: dbus_a_addr, data: dbus_a_data, wmsk: dbus_a_wmsk,
                              exc: fb_exc_e'(dbus_a_exc)};
   assign dbus_if.b_ready = dbus_b_ready;
   assign dbus_a_ready    = dbus_if.a_ready;
   assign dbus_b_valid    = dbus_if.b_valid;
   assign dbus_b_data     = dbus_if.b_rsp.data;
   assign dbus_b_exc      = dbus_if.b_rsp.exc;

   // Two masters onto one port
   fb_arbiter fb_arbiter_i (
      .clk   (clk),
      .rst_n (rst_n),
      .ibus  (ibus_if.slave),
      .dbus  (dbus_if.slave),
      .mbus  (mbus_if.master)
   );

   // Shared memory behind the arbiter
   fb_mem_slave fb_mem_slave_i (
      .clk   (clk),
      .rst_n (rst_n),
      .bus   (mbus_if.slave)
   );

endmodule

`default_nettype wire

/* verification/tb_fb_subsys.sv */
// Front-end bus subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "fb_bus_macros.svh"

module tb_fb_subsys
   import fb_bus_pkg::*;
();

   localparam int HALF = 20;
   localparam int TMO  = 200;
   localparam int NBP  = 12;

   logic                clk;
   logic                rst_n;
   logic                ibus_a_valid;
   logic                ibus_a_ready;
   logic [`FB_AW-1:0]   ibus_a_addr;
   logic [1:0]          ibus_a_exc;
   logic                ibus_b_valid;
   logic                ibus_b_ready;
   logic [`FB_IW-1:0]   ibus_b_data;
   logic [1:0]          ibus_b_exc;
   logic                dbus_a_valid;
   logic                dbus_a_ready;
   logic [`FB_AW-1:0]   dbus_a_addr;
   logic [`FB_DW-1:0]   dbus_a_data;
   logic [`FB_DW/8-1:0] dbus_a_wmsk;
   logic [1:0]          dbus_a_exc;
   logic                dbus_b_valid;
   logic                dbus_b_ready;
   logic [`FB_IW-1:0]   dbus_b_data;
   logic [1:0]          dbus_b_exc;

   // Shadow memory and expected {data, exc} per master
   logic [`FB_DW-1:0]   shadow [`FB_MEM_WORDS];
   logic [`FB_IW+1:0]   ibus_exp_q [$];
   logic [`FB_IW+1:0]   dbus_exp_q [$];
   logic [`FB_IW+1:0]   exp_w;
   logic [31:0]         lfsr;
   logic [31:0]         r_a;
   logic [31:0]         r_d;
   logic [31:0]         r_m;
   logic [31:0]         bp_r;
   logic                bp_mode;
   int                  hds_base;
   int                  dbus_hds_cnt;
   time                 ibus_start_t;
   time                 ibus_hds_t;
   // Last sample for hold checks under back-pressure
   logic                ibus_stall_q;
   logic                dbus_stall_q;
   logic [`FB_IW+1:0]   ibus_last;
   logic [`FB_IW+1:0]   dbus_last;
   // Pre-drawn back-pressure stimulus
   logic [31:0]         bp_daddr [NBP];
   logic [31:0]         bp_ddata [NBP];
   logic [3:0]          bp_dmsk [NBP];
   logic [31:0]         bp_iaddr [NBP];

   fb_subsys_top fb_subsys_top_i (.*);

   initial clk = 1'b0;
   always #HALF clk = ~clk;

   // One Galois LFSR step
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 32'hA300_0000;
      return n;
   endfunction

   // One step per bit taken
   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v[i] = lfsr[0];
         lfsr = lfsr_next(lfsr);
      end
   endtask

   // Expected response from the memory rules with the old word before any write
   function automatic logic [`FB_IW+1:0] ref_rsp(input logic [31:0] addr,
                                                 input logic [1:0] exc);
      if (exc != EXC_NONE)
         return {32'h0, exc};
      else if (addr[31:2] >= `FB_MEM_WORDS)
         return {32'h0, EXC_BUS};
      else
         return {shadow[addr[9:2]], EXC_NONE};
   endfunction

   // Byte merge into shadow skipped on faults and out-of-range
   task automatic shadow_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] wmsk, input logic [1:0] exc);
      if (exc == EXC_NONE && addr[31:2] < `FB_MEM_WORDS)
         for (int b = 0; b < 4; b++)
            if (wmsk[b])
               shadow[addr[9:2]][8*b +: 8] = data[8*b +: 8];
   endtask

   task automatic check_val(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
         $display("Test FAILED");
         $fatal(1);
      end
   endtask

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1);
   endtask

   // Drive a dbus request and return on its accepting edge
   task automatic dbus_req(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] wmsk, input logic [1:0] exc);
      int n;
      @(posedge clk);
      dbus_a_valid <= 1'b1;
      dbus_a_addr  <= addr;
      dbus_a_data  <= data;
      dbus_a_wmsk  <= wmsk;
      dbus_a_exc   <= exc;
      n = 0;
      @(negedge clk);
      while (!dbus_a_ready && n < TMO)
      begin
         @(negedge clk);
         n++;
      end
      if (!dbus_a_ready)
         stop_run("Timeout waiting for dbus request to be accepted");
      @(posedge clk);
      dbus_a_valid <= 1'b0;
      dbus_exp_q.push_back(ref_rsp(addr, exc));
      shadow_write(addr, data, wmsk, exc);
   endtask

   // Same for the read-only fetch side
   task automatic ibus_req(input logic [31:0] addr, input logic [1:0] exc);
      int n;
      @(posedge clk);
      ibus_start_t = $time;
      ibus_a_valid <= 1'b1;
      ibus_a_addr  <= addr;
      ibus_a_exc   <= exc;
      n = 0;
      @(negedge clk);
      while (!ibus_a_ready && n < TMO)
      begin
         @(negedge clk);
         n++;
      end
      if (!ibus_a_ready)
         stop_run("Timeout waiting for ibus request to be accepted");
      @(posedge clk);
      ibus_a_valid <= 1'b0;
      ibus_exp_q.push_back(ref_rsp(addr, exc));
   endtask

   function automatic logic busy();
      return (ibus_exp_q.size() != 0) || (dbus_exp_q.size() != 0) ||
             ibus_b_valid || dbus_b_valid;
   endfunction

   // Wait until all responses are taken and B channels are quiet
   task automatic wait_drained();
      int n;
      n = 0;
      @(negedge clk);
      while (busy() && n < TMO)
      begin
         @(negedge clk);
         n++;
      end
      if (busy())
         stop_run("Timeout waiting for outstanding responses to drain");
   endtask

   // dbus must be finished once ibus is first served
   task automatic wait_ibus_ready(input int base);
      int n;
      n = 0;
      @(negedge clk);
      while (!ibus_a_ready && n < TMO)
      begin
         @(negedge clk);
         n++;
      end
      if (!ibus_a_ready)
         stop_run("Timeout waiting for ibus_a_ready to rise");
      check_val("dbus_hds_cnt", dbus_hds_cnt - base, 1);
   endtask

   // Random b_ready in back-pressure phase and always ready otherwise
   always @(posedge clk)
   begin
      if (bp_mode)
      begin
         rand_bits(2, bp_r);
         ibus_b_ready <= bp_r[0];
         dbus_b_ready <= bp_r[1];
      end
      else
      begin
         ibus_b_ready <= 1'b1;
         dbus_b_ready <= 1'b1;
      end
   end

   // Compare every B handshake half a cycle before its edge
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         check_val("ibus_b_valid & dbus_b_valid", ibus_b_valid & dbus_b_valid, 0);
         if (ibus_stall_q)
         begin
            check_val("ibus_b_valid", ibus_b_valid, 1);
            check_val("ibus_b_data/exc", {ibus_b_data, ibus_b_exc}, ibus_last);
         end
         if (dbus_stall_q)
         begin
            check_val("dbus_b_valid", dbus_b_valid, 1);
            check_val("dbus_b_data/exc", {dbus_b_data, dbus_b_exc}, dbus_last);
         end
         if (ibus_b_valid && ibus_b_ready)
         begin
            if (ibus_exp_q.size() == 0)
               stop_run("ibus response arrived with no request pending");
            exp_w = ibus_exp_q.pop_front();
            check_val("ibus_b_data", ibus_b_data, exp_w[`FB_IW+1:2]);
            check_val("ibus_b_exc", ibus_b_exc, exp_w[1:0]);
            ibus_hds_t = $time + HALF;
         end
         if (dbus_b_valid && dbus_b_ready)
         begin
            if (dbus_exp_q.size() == 0)
               stop_run("dbus response arrived with no request pending");
            exp_w = dbus_exp_q.pop_front();
            check_val("dbus_b_data", dbus_b_data, exp_w[`FB_IW+1:2]);
            check_val("dbus_b_exc", dbus_b_exc, exp_w[1:0]);
            dbus_hds_cnt++;
         end
         ibus_stall_q = ibus_b_valid & ~ibus_b_ready;
         dbus_stall_q = dbus_b_valid & ~dbus_b_ready;
         ibus_last    = {ibus_b_data, ibus_b_exc};
         dbus_last    = {dbus_b_data, dbus_b_exc};
      end
   end

   initial
   begin
      lfsr         = 32'd46;
      bp_mode      = 1'b0;
      dbus_hds_cnt = 0;
      ibus_stall_q = 1'b0;
      dbus_stall_q = 1'b0;
      for (int w = 0; w < `FB_MEM_WORDS; w++)
         shadow[w] = '0;
      rst_n        <= 1'b0;
      ibus_a_valid <= 1'b0;
      ibus_a_addr  <= '0;
      ibus_a_exc   <= '0;
      ibus_b_ready <= 1'b1;
      dbus_a_valid <= 1'b0;
      dbus_a_addr  <= '0;
      dbus_a_data  <= '0;
      dbus_a_wmsk  <= '0;
      dbus_a_exc   <= '0;
      dbus_b_ready <= 1'b1;
      // Reset state during reset
      repeat (8)
      begin
         @(negedge clk);
         check_val("ready/valid during reset",
                   {ibus_a_ready, dbus_a_ready, ibus_b_valid, dbus_b_valid}, 0);
      end
      @(posedge clk);
      rst_n <= 1'b1;
      // And just after release
      @(negedge clk);
      check_val("ready/valid after reset",
                {ibus_a_ready, dbus_a_ready, ibus_b_valid, dbus_b_valid}, 0);
      // Masked writes each read back
      for (int k = 0; k < 16; k++)
      begin
         rand_bits(4, r_a);
         rand_bits(32, r_d);
         rand_bits(4, r_m);
         dbus_req({26'h0, r_a[3:0], 2'b00}, r_d, r_m[3:0], EXC_NONE);
         wait_drained();
         dbus_req({26'h0, r_a[3:0], 2'b00}, 32'h0, 4'h0, EXC_NONE);
         wait_drained();
      end
      // Fetches on an idle bus with fixed latency
      for (int k = 0; k < 8; k++)
      begin
         rand_bits(4, r_a);
         ibus_req({26'h0, r_a[3:0], 2'b00}, EXC_NONE);
         wait_drained();
         check_val("ibus latency", (ibus_hds_t - ibus_start_t) / (2 * HALF), 3);
      end
      // Same-cycle requests with dbus first
      for (int k = 0; k < 4; k++)
      begin
         rand_bits(4, r_a);
         rand_bits(32, r_d);
         rand_bits(4, r_m);
         hds_base = dbus_hds_cnt;
         fork
            dbus_req({26'h0, r_a[3:0], 2'b00}, r_d, r_m[3:0], EXC_NONE);
            ibus_req({26'h0, r_a[3:0], 2'b00}, EXC_NONE);
            wait_ibus_ready(hds_base);
         join
         wait_drained();
      end
      // Faulted and out-of-range requests then read-backs
      dbus_req(32'h0000_0010, 32'hFFFF_FFFF, 4'hF, EXC_PAGE);
      dbus_req(32'h0000_0014, 32'hFFFF_FFFF, 4'hF, EXC_PRIV);
      ibus_req(32'h0000_0010, EXC_PAGE);
      dbus_req(32'h0000_0400, 32'h1234_5678, 4'hF, EXC_NONE);
      ibus_req(32'h8000_0000, EXC_NONE);
      dbus_req(32'h0000_0010, 32'h0, 4'h0, EXC_NONE);
      dbus_req(32'h0000_0014, 32'h0, 4'h0, EXC_NONE);
      ibus_req(32'h0000_0000, EXC_NONE);
      wait_drained();
      // Back-pressure with both masters running
      for (int k = 0; k < NBP; k++)
      begin
         rand_bits(4, r_a);
         rand_bits(32, r_d);
         rand_bits(4, r_m);
         bp_daddr[k] = {26'h0, r_a[3:0], 2'b00};
         bp_ddata[k] = r_d;
         bp_dmsk[k]  = r_m[3:0];
         rand_bits(4, r_a);
         bp_iaddr[k] = {26'h0, r_a[3:0], 2'b00};
      end
      bp_mode = 1'b1;
      fork
         for (int k = 0; k < NBP; k++)
            dbus_req(bp_daddr[k], bp_ddata[k], bp_dmsk[k], EXC_NONE);
         for (int k = 0; k < NBP; k++)
            ibus_req(bp_iaddr[k], EXC_NONE);
      join
      wait_drained();
      bp_mode = 1'b0;
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

/* fb_subsys.f */
+incdir+rtl
rtl/fb_bus_pkg.sv
rtl/fb_bus_if.sv
rtl/fb_arbiter.sv
rtl/fb_mem_slave.sv
rtl/fb_subsys_top.sv
verification/tb_fb_subsys.sv

/* Bender.yml */
package:
  name: fb_subsys

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fb_bus_pkg.sv
      - rtl/fb_bus_if.sv
      - rtl/fb_arbiter.sv
      - rtl/fb_mem_slave.sv
      - rtl/fb_subsys_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - verification/tb_fb_subsys.sv

export_include_dirs:
  - rtl
